//--- compile.f
design/wave_cmd_pkg.sv
design/rx_char_decode.sv
design/cmd_fsm.sv
design/samp_gen_ctl.sv
design/samp_ram.sv
design/cmd_parse_top.sv
tests/tb_clk_gen.sv
tests/tb_cmd_parse.sv

//--- design/cmd_fsm.sv
// Command parser state machine
`timescale 1ns/10ps

module cmd_fsm (
  input  logic                                clk_rx,
  input  logic                                rst_clk_rx,
  input  wave_cmd_pkg::rx_char_t              rx_char,
  input  logic                                send_resp_done,  // One clock
  input  logic [wave_cmd_pkg::SAMP_WID-1:0]   ram_dout,
  output wave_cmd_pkg::resp_req_t             resp_req,
  output wave_cmd_pkg::samp_cfg_t             samp_cfg,
  output wave_cmd_pkg::ram_req_t              ram_req,
  output wave_cmd_pkg::go_cmd_e               go_cmd           // One clock
);

  wave_cmd_pkg::fsm_state_e                 state;
  wave_cmd_pkg::cmd_code_e                  cmd_in;    // Letter on the bus
  wave_cmd_pkg::cmd_code_e                  cur_cmd;   // Letter being served
  logic [4*wave_cmd_pkg::MAX_ARG_CH-5:0]    arg_sav;   // Digits so far
  logic [wave_cmd_pkg::ARG_CNT_WID-1:0]     arg_cnt;   // Digits still to come
  logic [4*wave_cmd_pkg::MAX_ARG_CH-1:0]    arg_val;   // Digits incl. current
  logic                                     arg_ok;    // Range check passed

  // Response request, new type and data
  function automatic wave_cmd_pkg::resp_req_t mk_resp(
    input wave_cmd_pkg::resp_type_e        rtype,
    input logic [wave_cmd_pkg::SAMP_WID-1:0] data
  );
    return '{val: 1'b1, rtype: rtype, data: data};
  endfunction

  assign cmd_in  = wave_cmd_pkg::cmd_code_e'(rx_char.ch[6:0]);
  assign arg_val = {arg_sav, rx_char.digit};             // MS digit first

  // *************************************************************************
  // Argument range checks
  // *************************************************************************

  always_comb
  begin
    case (cur_cmd)
      wave_cmd_pkg::CMD_W: arg_ok = arg_val[31:16] <= wave_cmd_pkg::RAM_MAX;
      wave_cmd_pkg::CMD_R: arg_ok = arg_val[15:0] <= wave_cmd_pkg::RAM_MAX;
      wave_cmd_pkg::CMD_N: arg_ok = (arg_val[15:0] >= wave_cmd_pkg::NSAMP_MIN) &&
                                    (arg_val[15:0] <= wave_cmd_pkg::NSAMP_MAX);
      wave_cmd_pkg::CMD_P: arg_ok = arg_val[15:0] >= wave_cmd_pkg::PRESCALE_MIN;
      default:             arg_ok = 1'b0;
    endcase
  end

  // *************************************************************************
  // Main state machine
  // *************************************************************************

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      state              <= wave_cmd_pkg::ST_IDLE;
      arg_cnt            <= '0;
      resp_req.val       <= 1'b0;
      resp_req.rtype     <= wave_cmd_pkg::RESP_ERR;
      samp_cfg.nsamp     <= (wave_cmd_pkg::NSAMP_WID+1)'(wave_cmd_pkg::NSAMP_MIN);
      samp_cfg.prescale  <= wave_cmd_pkg::PRE_WID'(wave_cmd_pkg::PRESCALE_MIN);
      samp_cfg.nsamp_new <= 1'b0;
      samp_cfg.pre_new   <= 1'b0;
      ram_req.we         <= 1'b0;
      go_cmd             <= wave_cmd_pkg::GO_NONE;
    end
    else
    begin
      samp_cfg.nsamp_new <= 1'b0;                        // Pulses by default
      samp_cfg.pre_new   <= 1'b0;
      ram_req.we         <= 1'b0;
      go_cmd             <= wave_cmd_pkg::GO_NONE;
      case (state)
        wave_cmd_pkg::ST_IDLE:                           // Wait for '*'
          if (rx_char.stb && rx_char.ch[6:0] == wave_cmd_pkg::CH_STAR)
            state <= wave_cmd_pkg::ST_CMD_WAIT;
        wave_cmd_pkg::ST_CMD_WAIT:
          if (rx_char.stb)
          begin
            cur_cmd <= cmd_in;
            state   <= wave_cmd_pkg::ST_SEND_RESP;       // Unless args follow
            case (cmd_in)
              wave_cmd_pkg::CMD_W:
              begin
                arg_cnt <= wave_cmd_pkg::ARG_CNT_WID'(wave_cmd_pkg::MAX_ARG_CH - 1);
                state   <= wave_cmd_pkg::ST_GET_ARG;     // Address and data
              end
              wave_cmd_pkg::CMD_R, wave_cmd_pkg::CMD_N, wave_cmd_pkg::CMD_P:
              begin
                arg_cnt <= wave_cmd_pkg::ARG_CNT_WID'(wave_cmd_pkg::MAX_ARG_CH/2 - 1);
                state   <= wave_cmd_pkg::ST_GET_ARG;     // Four digits
              end
              wave_cmd_pkg::CMD_N_LC:
                resp_req <= mk_resp(wave_cmd_pkg::RESP_DATA, 16'(samp_cfg.nsamp));
              wave_cmd_pkg::CMD_P_LC:
                resp_req <= mk_resp(wave_cmd_pkg::RESP_DATA, samp_cfg.prescale);
              wave_cmd_pkg::CMD_G:
              begin
                resp_req <= mk_resp(wave_cmd_pkg::RESP_OK, '0);
                go_cmd   <= wave_cmd_pkg::GO_PULSE;
              end
              wave_cmd_pkg::CMD_C:
              begin
                resp_req <= mk_resp(wave_cmd_pkg::RESP_OK, '0);
                go_cmd   <= wave_cmd_pkg::GO_CONT;
              end
              wave_cmd_pkg::CMD_H:
              begin
                resp_req <= mk_resp(wave_cmd_pkg::RESP_OK, '0);
                go_cmd   <= wave_cmd_pkg::GO_HALT;
              end
              default: resp_req <= mk_resp(wave_cmd_pkg::RESP_ERR, '0);  // Unknown
            endcase
          end
        wave_cmd_pkg::ST_GET_ARG:
          if (rx_char.stb)
          begin
            if (rx_char.is_digit && arg_cnt != '0)       // More to come
            begin
              arg_sav <= arg_val[4*wave_cmd_pkg::MAX_ARG_CH-5:0];
              arg_cnt <= arg_cnt - 1'b1;
            end
            else if (!rx_char.is_digit || !arg_ok)       // Bad digit or range
            begin
              resp_req <= mk_resp(wave_cmd_pkg::RESP_ERR, '0);
              state    <= wave_cmd_pkg::ST_SEND_RESP;
            end
            else if (cur_cmd == wave_cmd_pkg::CMD_R)
            begin
              ram_req.addr <= arg_val[wave_cmd_pkg::NSAMP_WID-1:0];
              state        <= wave_cmd_pkg::ST_READ_RAM;
            end
            else
            begin
              resp_req <= mk_resp(wave_cmd_pkg::RESP_OK, '0);
              state    <= wave_cmd_pkg::ST_SEND_RESP;
              if (cur_cmd == wave_cmd_pkg::CMD_W)
                ram_req <= '{we: 1'b1, addr: arg_val[16 +: wave_cmd_pkg::NSAMP_WID],
                             din: arg_val[15:0]};
              else if (cur_cmd == wave_cmd_pkg::CMD_N)
              begin
                samp_cfg.nsamp     <= arg_val[wave_cmd_pkg::NSAMP_WID:0];
                samp_cfg.nsamp_new <= 1'b1;
              end
              else
              begin
                samp_cfg.prescale  <= arg_val[15:0];     // P
                samp_cfg.pre_new   <= 1'b1;
              end
            end
          end
        wave_cmd_pkg::ST_READ_RAM:                       // Address at RAM
          state <= wave_cmd_pkg::ST_READ_RAM2;
        wave_cmd_pkg::ST_READ_RAM2:                      // Read data valid
        begin
          resp_req <= mk_resp(wave_cmd_pkg::RESP_DATA, ram_dout);
          state    <= wave_cmd_pkg::ST_SEND_RESP;
        end
        wave_cmd_pkg::ST_SEND_RESP:                      // Hold request
          if (send_resp_done)
          begin
            resp_req.val <= 1'b0;
            state        <= wave_cmd_pkg::ST_IDLE;
          end
        default: state <= wave_cmd_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

//--- design/cmd_parse_top.sv
// Command parser top level
`timescale 1ns/10ps

module cmd_parse_top (
  input  logic                              clk_rx,
  input  logic                              rst_clk_rx,
  input  logic [7:0]                        rx_data,
  input  logic                              rx_data_rdy,
  input  logic                              char_fifo_full,
  input  logic                              send_resp_done,
  output logic                              send_char_val,
  output logic [7:0]                        send_char,
  output logic                              send_resp_val,
  output wave_cmd_pkg::resp_type_e          send_resp_type,
  output logic [wave_cmd_pkg::SAMP_WID-1:0] send_resp_data,
  output wave_cmd_pkg::samp_cfg_t           samp_cfg,
  output logic                              samp_gen_go
);

  wave_cmd_pkg::rx_char_t            rx_char;    // Decoded character
  wave_cmd_pkg::resp_req_t           resp_req;
  wave_cmd_pkg::ram_req_t            ram_req;
  wave_cmd_pkg::go_cmd_e             go_cmd;
  logic [wave_cmd_pkg::SAMP_WID-1:0] ram_dout;

  // ************************************************************************
  // Blocks
  // ************************************************************************

  rx_char_decode rx_char_decode_i (
    .clk_rx, .rst_clk_rx, .rx_data, .rx_data_rdy, .char_fifo_full,
    .rx_char, .send_char_val, .send_char
  );

  cmd_fsm cmd_fsm_i (
    .clk_rx, .rst_clk_rx, .rx_char, .send_resp_done, .ram_dout,
    .resp_req, .samp_cfg, .ram_req, .go_cmd
  );

  samp_gen_ctl samp_gen_ctl_i (.clk_rx, .rst_clk_rx, .go_cmd, .samp_gen_go);

  samp_ram samp_ram_i (.clk_rx, .ram_req, .ram_dout);

  // Response request out to the response generator
  assign send_resp_val  = resp_req.val;
  assign send_resp_type = resp_req.rtype;
  assign send_resp_data = resp_req.data;

endmodule

//--- design/rx_char_decode.sv
// Receive character accept and hex decode
`timescale 1ns/10ps

module rx_char_decode (
  input  logic                   clk_rx,
  input  logic                   rst_clk_rx,
  input  logic [7:0]             rx_data,
  input  logic                   rx_data_rdy,     // Level, several clocks
  input  logic                   char_fifo_full,
  output wave_cmd_pkg::rx_char_t rx_char,
  output logic                   send_char_val,   // Echo strobe
  output logic [7:0]             send_char
);

  logic       old_rdy;      // Ready on previous clock
  logic       new_char;     // First clock of a ready level, room in FIFO
  logic       is_digit;
  logic [3:0] digit;
  logic       stb_q;
  logic [7:0] ch_q;
  logic       is_digit_q;
  logic [3:0] digit_q;

  assign new_char = rx_data_rdy && !old_rdy && !char_fifo_full;

  // Hex digit from low 7 bits
  always_comb
  begin
    is_digit = 1'b1;
    digit    = rx_data[3:0];                         // 0-9 map straight
    if ((rx_data[6:0] >= 7'h41 && rx_data[6:0] <= 7'h46) ||
        (rx_data[6:0] >= 7'h61 && rx_data[6:0] <= 7'h66))
      digit = rx_data[3:0] + 4'h9;                   // A-F, a-f give 10-15
    else if (!(rx_data[6:0] >= 7'h30 && rx_data[6:0] <= 7'h39))
    begin
      is_digit = 1'b0;
      digit    = 4'h0;
    end
  end

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      old_rdy <= 1'b0;
      stb_q   <= 1'b0;
    end
    else
    begin
      old_rdy <= rx_data_rdy;
      stb_q   <= new_char;                           // Character clock
    end
  end

  // Character payload, held between strobes
  always_ff @(posedge clk_rx)
  begin
    if (new_char)
    begin
      ch_q       <= rx_data;
      is_digit_q <= is_digit;
      digit_q    <= digit;
    end
  end

  assign rx_char       = '{stb: stb_q, ch: ch_q, is_digit: is_digit_q, digit: digit_q};
  assign send_char_val = stb_q;                      // Echo with the strobe
  assign send_char     = ch_q;

endmodule

//--- design/samp_gen_ctl.sv
// Sample generator enable control
`timescale 1ns/10ps

module samp_gen_ctl (
  input  logic                  clk_rx,
  input  logic                  rst_clk_rx,
  input  wave_cmd_pkg::go_cmd_e go_cmd,       // One clock per command
  output logic                  samp_gen_go   // Enable to sample generator
);

  logic [wave_cmd_pkg::GO_CTR_WID-1:0] go_ctr;     // Counts GO_PW-1 to 0
  logic                                go_cont;    // Continuous mode
  logic                                cont_nxt;
  logic                                go_pulse;

  assign go_pulse = (go_cmd == wave_cmd_pkg::GO_PULSE);

  // Continuous flag, next value
  always_comb
  begin
    case (go_cmd)
      wave_cmd_pkg::GO_CONT: cont_nxt = 1'b1;
      wave_cmd_pkg::GO_HALT: cont_nxt = 1'b0;
      default:               cont_nxt = go_cont;
    endcase
  end

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      go_ctr      <= '0;
      go_cont     <= 1'b0;
      samp_gen_go <= 1'b0;
    end
    else
    begin
      if (go_ctr != '0)
        go_ctr <= go_ctr - 1'b1;                   // Pulse running
      else if (go_pulse)
        go_ctr <= wave_cmd_pkg::GO_CTR_WID'(wave_cmd_pkg::GO_PW - 1);
      go_cont     <= cont_nxt;
      samp_gen_go <= go_pulse || (go_ctr != '0) || cont_nxt;
    end
  end

endmodule

//--- design/samp_ram.sv
// Sample RAM
`timescale 1ns/10ps

module samp_ram (
  input  logic                              clk_rx,
  input  wave_cmd_pkg::ram_req_t            ram_req,
  output logic [wave_cmd_pkg::SAMP_WID-1:0] ram_dout   // One clock after addr
);

  // 1024 x 16 sample storage
  logic [wave_cmd_pkg::SAMP_WID-1:0] mem [0:wave_cmd_pkg::RAM_MAX];

  always_ff @(posedge clk_rx)
  begin
    if (ram_req.we)
      mem[ram_req.addr] <= ram_req.din;
  end

  // Registered read, old data on a write clock
  always_ff @(posedge clk_rx)
  begin
    ram_dout <= mem[ram_req.addr];
  end

endmodule

//--- design/wave_cmd_pkg.sv
// Wave generator command definitions
package wave_cmd_pkg;

  // *************************************************************************
  // Widths and limits
  // *************************************************************************

  localparam int NSAMP_WID    = 10;                 // RAM address bits
  localparam int SAMP_WID     = 16;                 // Bits per sample
  localparam int PRE_WID      = 16;                 // Prescale width
  localparam int RAM_MAX      = 2**NSAMP_WID - 1;   // Last RAM location
  localparam int NSAMP_MIN    = 1;
  localparam int NSAMP_MAX    = 2**NSAMP_WID;       // Full RAM
  localparam int PRESCALE_MIN = 32;                 // One DAC SPI cycle
  localparam int GO_PW        = 3;                  // Go pulse, clk_rx cycles
  localparam int MAX_ARG_CH   = 8;                  // Longest argument, W
  localparam int ARG_CNT_WID  = $clog2(MAX_ARG_CH);
  localparam int GO_CTR_WID   = $clog2(GO_PW);

  localparam logic [6:0] CH_STAR = 7'h2a;           // Command prefix

  // *************************************************************************
  // Encodings
  // *************************************************************************

  // Command letters, low 7 bits of ASCII
  typedef enum logic [6:0] {
    CMD_W    = 7'h57,   // Write RAM
    CMD_R    = 7'h52,   // Read RAM
    CMD_N    = 7'h4e,   // Set nsamp
    CMD_P    = 7'h50,   // Set prescale
    CMD_N_LC = 7'h6e,   // Show nsamp
    CMD_P_LC = 7'h70,   // Show prescale
    CMD_G    = 7'h47,   // Go once
    CMD_C    = 7'h43,   // Continuous
    CMD_H    = 7'h48    // Halt
  } cmd_code_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_CMD_WAIT, ST_GET_ARG, ST_READ_RAM, ST_READ_RAM2, ST_SEND_RESP
  } fsm_state_e;

  typedef enum logic [1:0] {
    RESP_OK   = 2'b00,
    RESP_ERR  = 2'b01,
    RESP_DATA = 2'b11
  } resp_type_e;

  typedef enum logic [1:0] {GO_NONE, GO_PULSE, GO_CONT, GO_HALT} go_cmd_e;

  // *************************************************************************
  // Bundles between blocks
  // *************************************************************************

  typedef struct packed {
    logic       stb;        // Accepted character, one clock
    logic [7:0] ch;
    logic       is_digit;   // Hex digit flag
    logic [3:0] digit;
  } rx_char_t;

  typedef struct packed {
    logic                val;   // Held until done
    resp_type_e          rtype;
    logic [SAMP_WID-1:0] data;
  } resp_req_t;

  typedef struct packed {
    logic [NSAMP_WID:0] nsamp;   // One extra bit to hold 1024
    logic [PRE_WID-1:0] prescale;
    logic               nsamp_new;
    logic               pre_new;
  } samp_cfg_t;

  typedef struct packed {
    logic                 we;
    logic [NSAMP_WID-1:0] addr;
    logic [SAMP_WID-1:0]  din;
  } ram_req_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the command parser testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_cmd_parse -f compile.f -Mdir obj_dir > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_cmd_parse > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log || exit 1
exit 0

//--- tests/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_rx,
  output logic rst_clk_rx
);

  initial
  begin
    clk_rx = 1'b0;
    forever
      #(PERIOD/2) clk_rx = ~clk_rx;
  end

  // Reset over four rising edges, released on a falling edge
  initial
  begin
    rst_clk_rx = 1'b1;
    repeat (4) @(posedge clk_rx);
    @(negedge clk_rx);
    rst_clk_rx = 1'b0;
  end

endmodule

//--- tests/tb_cmd_parse.sv
// Command parser testbench
`timescale 1ns/10ps

module tb_cmd_parse;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_CMDS     = 300;
  localparam int CMD_MAX_CLKS = 250;   // Ten characters, each maybe sent twice

  logic                     clk_rx;
  logic                     rst_clk_rx;
  logic [7:0]               rx_data;
  logic                     rx_data_rdy;
  logic                     char_fifo_full;
  logic                     send_resp_done;
  logic                     send_char_val;
  logic [7:0]               send_char;
  logic                     send_resp_val;
  wave_cmd_pkg::resp_type_e send_resp_type;
  logic [15:0]              send_resp_data;
  wave_cmd_pkg::samp_cfg_t  samp_cfg;
  logic                     samp_gen_go;

  integer      seed = 90593;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  logic [15:0] mem_m [0:wave_cmd_pkg::RAM_MAX];       // RAM model
  bit          written_m [0:wave_cmd_pkg::RAM_MAX];
  int          nsamp_m = 1;                           // Settings after reset
  int          pre_m = 32;
  int          nsamp_pulses = 0;
  int          pre_pulses = 0;
  time         char_t = 0;        // Falling edge after the last character clock
  time         rise_t = 0;        // Falling edge where send_resp_val rose
  time         go_time = 0;       // Go command due at samp_gen_go
  byte         go_code = 0;
  bit          go_arm = 1'b0;     // Next accepted character is G, C or H
  bit          go_cont_m = 1'b0;
  int          go_left_m = 0;
  logic        val_q = 1'b0;
  byte         cmd_letters [10] = '{"W", "R", "N", "P", "n", "p", "G", "C", "H", "S"};
  byte         bad_letters [4] = '{"S", "s", "X", "q"};

  tb_clk_gen #(.PERIOD(CLK_PERIOD)) tb_clk_gen_i (.clk_rx, .rst_clk_rx);

  cmd_parse_top cmd_parse_top_i (.*);

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Mostly a few low addresses so reads find earlier writes
  function automatic logic [15:0] pick_addr();
    if (rand_below(8) == 0)
      return 16'(1024 + rand_below(64512));          // Past the RAM
    return 16'(rand_below(32));
  endfunction

  function automatic byte hex_char(input logic [3:0] d);
    if (d < 10)
      return byte'("0" + d);
    return byte'((rand_below(2) ? "a" : "A") + d - 10);   // Either case
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    chk_cnt++;
    assert (got == exp)
    else
    begin
      err_cnt++;
      $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // ************************************************************************
  // Character driver, echo checked on the first clock
  // ************************************************************************

  task automatic drive_char(input byte ch, input bit full);
    int hold;
    int gap;
    int k;
    hold           = 2 + rand_below(4);
    gap            = 1 + rand_below(4);
    rx_data        = ch;
    char_fifo_full = full;
    rx_data_rdy    = 1'b1;
    @(negedge clk_rx);
    check_value("send_char_val", send_char_val, !full);
    if (!full)
    begin
      check_value("send_char", send_char, ch);
      char_t = $time;
      if (go_arm)
      begin
        go_code = ch;
        go_time = $time + 2*CLK_PERIOD;            // Enable two clocks on
        go_arm  = 1'b0;
      end
    end
    for (k = 1; k < hold + gap; k++)
    begin
      if (k == hold)
        rx_data_rdy = 1'b0;
      @(negedge clk_rx);
      check_value("send_char_val", send_char_val, 0);   // One echo only
    end
  endtask

  // Some characters meet a full FIFO first and are sent again
  task automatic send_accepted(input byte ch);
    if (rand_below(20) == 0)
      drive_char(ch, 1'b1);
    drive_char(ch, 1'b0);
  endtask

  // ************************************************************************
  // One command, expected response and settings
  // ************************************************************************

  task automatic run_command();
    int                       ndig;
    int                       bad_pos;
    int                       d;
    int                       n;
    int                       n0;
    int                       p0;
    int                       lat;
    int                       exp_data;
    bit                       ok;
    bit                       chk_data;
    byte                      letter;
    logic [31:0]              arg;
    wave_cmd_pkg::resp_type_e exp_type;
    letter = cmd_letters[rand_below(10)];
    if (letter == "S")
      letter = bad_letters[rand_below(4)];         // Unknown, speed too
    ndig = (letter == "W") ? 8 : (letter inside {"R", "N", "P"}) ? 4 : 0;
    case (letter)
      "W": arg = {pick_addr(), 16'(rand_below(65536))};
      "R": arg = 32'(pick_addr());
      "N": arg = 32'(rand_below(4) == 0 ? rand_below(65536) : rand_below(1100));
      "P": arg = 32'(rand_below(4) == 0 ? rand_below(65536) : rand_below(64));
      default: arg = '0;
    endcase
    bad_pos = (ndig > 0 && rand_below(20) == 0) ? rand_below(ndig) : -1;
    ok      = (bad_pos < 0);
    case (letter)
      "W": ok = ok && (arg[31:16] <= wave_cmd_pkg::RAM_MAX);
      "R": ok = ok && (arg[15:0] <= wave_cmd_pkg::RAM_MAX);
      "N": ok = ok && (arg[15:0] >= wave_cmd_pkg::NSAMP_MIN) &&
                (arg[15:0] <= wave_cmd_pkg::NSAMP_MAX);
      "P": ok = ok && (arg[15:0] >= wave_cmd_pkg::PRESCALE_MIN);
      "n", "p", "G", "C", "H": ok = 1'b1;
      default: ok = 1'b0;
    endcase
    exp_type = !ok ? wave_cmd_pkg::RESP_ERR :
               (letter inside {"R", "n", "p"}) ? wave_cmd_pkg::RESP_DATA :
               wave_cmd_pkg::RESP_OK;
    case (letter)
      "n": exp_data = nsamp_m;
      "p": exp_data = pre_m;
      "R": exp_data = ok ? int'(mem_m[arg[9:0]]) : 0;
      default: exp_data = 0;
    endcase
    chk_data = (exp_type == wave_cmd_pkg::RESP_DATA) &&
               !(letter == "R" && !written_m[arg[9:0]]);   // Unwritten word
    lat      = (ok && letter == "R") ? 3 : 1;      // Address and wait clocks
    n0       = nsamp_pulses;
    p0       = pre_pulses;

    send_accepted("*");
    go_arm = letter inside {"G", "C", "H"};
    send_accepted(letter);
    for (d = 0; d < ndig; d++)
    begin
      if (d == bad_pos)
      begin
        send_accepted("g");                        // Answered at once
        break;
      end
      send_accepted(hex_char(arg[4*(ndig-1-d) +: 4]));   // MS digit first
    end

    for (n = 0; n < 20 && !send_resp_val; n++)
      @(negedge clk_rx);
    assert (send_resp_val)
    else
    begin
      err_cnt++;
      $display("error %0t no response request after command %c", $time, letter);
    end
    if (send_resp_val)
    begin
      check_value("send_resp_type", send_resp_type, exp_type);
      if (chk_data)
        check_value("send_resp_data", send_resp_data, exp_data);
      repeat (1 + rand_below(6))
      begin
        @(negedge clk_rx);
        check_value("send_resp_val", send_resp_val, 1);   // Held for done
      end
      send_resp_done = 1'b1;
      @(negedge clk_rx);
      send_resp_done = 1'b0;
      check_value("send_resp_val", send_resp_val, 0);
      check_value("send_resp_val rise", int'(rise_t), int'(char_t) + lat*CLK_PERIOD);
    end

    if (ok && letter == "W")
    begin
      mem_m[arg[25:16]]     = arg[15:0];
      written_m[arg[25:16]] = 1'b1;
    end
    if (ok && letter == "N")
      nsamp_m = arg[15:0];
    if (ok && letter == "P")
      pre_m = arg[15:0];
    check_value("nsamp_new pulses", nsamp_pulses - n0, ok && letter == "N");
    check_value("pre_new pulses", pre_pulses - p0, ok && letter == "P");
    check_value("samp_cfg.nsamp", samp_cfg.nsamp, nsamp_m);
    check_value("samp_cfg.prescale", samp_cfg.prescale, pre_m);
  endtask

  // Enable model and edge counters, every falling edge
  always @(negedge clk_rx)
  begin
    if ($time >= CLK_PERIOD)
    begin
      if ($time == go_time)
        case (go_code)
          "G": go_left_m = wave_cmd_pkg::GO_PW;
          "C": go_cont_m = 1'b1;
          "H": go_cont_m = 1'b0;
          default: ;
        endcase
      check_value("samp_gen_go", samp_gen_go, go_cont_m || go_left_m > 0);
      if (go_left_m > 0)
        go_left_m--;
      if (send_resp_val && !val_q)
        rise_t = $time;
      val_q        = send_resp_val;
      nsamp_pulses += samp_cfg.nsamp_new;
      pre_pulses   += samp_cfg.pre_new;
    end
  end

  initial
  begin
    rx_data        = '0;
    rx_data_rdy    = 1'b0;
    char_fifo_full = 1'b0;
    send_resp_done = 1'b0;
    @(negedge rst_clk_rx);
    repeat (2) @(negedge clk_rx);
    repeat (NUM_CMDS) run_command();
    repeat (4) @(negedge clk_rx);
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog, worst case for every command
  initial
  begin
    #(NUM_CMDS * CMD_MAX_CLKS * CLK_PERIOD);
    $display("watchdog expired before all commands ended, checks %0d errors %0d",
             chk_cnt, err_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule
